// ==== logic/event_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module event_capture (
	input  logic clock,
	input  logic arst_n,
	input  logic red_event,
	input  logic green_event,
	input  logic blue_event,
	input  logic pick_event,
	input  logic depo_event,
	output logic event_valid,
	output uart_msg_pkg::msg_id_t event_id
);

	localparam int NUM_EVENTS = 5;

	logic [NUM_EVENTS-1:0] raw;
	logic [NUM_EVENTS-1:0] sync1;
	logic [NUM_EVENTS-1:0] sync2;
	logic [NUM_EVENTS-1:0] prev;
	logic [NUM_EVENTS-1:0] rise;
	uart_msg_pkg::msg_id_t rise_id;

	assign raw = {depo_event, pick_event, blue_event, green_event, red_event};
	assign rise = sync2 & ~prev;

	// Deposit wins over pick, pick over blue, and so on down to red
	always_comb begin
		if (rise[4])
			rise_id = uart_msg_pkg::MSG_DEPO;
		else if (rise[3])
			rise_id = uart_msg_pkg::MSG_PICK;
		else if (rise[2])
			rise_id = uart_msg_pkg::MSG_BLUE;
		else if (rise[1])
			rise_id = uart_msg_pkg::MSG_GREEN;
		else
			rise_id = uart_msg_pkg::MSG_RED;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			sync1 <= '0;
			sync2 <= '0;
			prev <= '0;
			event_valid <= 1'b0;
		end else begin
			sync1 <= raw; // Two-flop synchronizer
			sync2 <= sync1;
			prev <= sync2;
			event_valid <= |rise;
		end
	end

	always_ff @(posedge clock) begin
		event_id <= rise_id;
	end

	// Reported id is the highest input that rose
	a_event_id_legal: assert property (@(posedge clock) disable iff (!arst_n)
		event_valid |-> ($past(rise) >> event_id) == NUM_EVENTS'(1));

endmodule

`default_nettype wire

// ==== logic/msg_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_msg_defines.svh"

module msg_rom (
	msg_rom_if.rom rom
);

	localparam int STR_W = `UART_DATA_BITS * `MSG_MAX_LEN;

	typedef logic [STR_W-1:0] msg_str_t;

	//////////////////////////////
	// Status strings
	//////////////////////////////

	localparam msg_str_t RED_STR   = "SI-SIN1-P-#";
	localparam msg_str_t GREEN_STR = "SI-SIN1-N-#";
	localparam msg_str_t BLUE_STR  = "SI-SIN3-W-#";
	localparam msg_str_t PICK_STR  = "S-P-DZN1-N-#";
	localparam msg_str_t DEPO_STR  = "S-D-DZN1-N-#";

	msg_str_t str;
	uart_msg_pkg::char_idx_t len;

	always_comb begin
		case (rom.msg_id)
			uart_msg_pkg::MSG_RED: begin
				str = RED_STR;
				len = 4'd11;
			end
			uart_msg_pkg::MSG_GREEN: begin
				str = GREEN_STR;
				len = 4'd11;
			end
			uart_msg_pkg::MSG_BLUE: begin
				str = BLUE_STR;
				len = 4'd11;
			end
			uart_msg_pkg::MSG_PICK: begin
				str = PICK_STR;
				len = 4'd12;
			end
			uart_msg_pkg::MSG_DEPO: begin
				str = DEPO_STR;
				len = 4'd12;
			end
			default: begin
				str = {`MSG_MAX_LEN{"#"}};
				len = 4'd1;
			end
		endcase
	end

	// Strings are right-aligned, so the first character sits highest
	always_comb begin
		rom.last = (rom.char_idx == len - 1'b1);
		if (rom.char_idx < len)
			rom.char = str[`UART_DATA_BITS*(len-1-rom.char_idx) +: `UART_DATA_BITS];
		else
			rom.char = "#";
	end

endmodule

`default_nettype wire

// ==== logic/msg_rom_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface msg_rom_if;

	uart_msg_pkg::msg_id_t msg_id;
	uart_msg_pkg::char_idx_t char_idx;
	uart_msg_pkg::char_t char; // Valid in the same cycle
	logic last; // char_idx is the final character

	modport seq (
		output msg_id,
		output char_idx,
		input  char,
		input  last
	);

	modport rom (
		input  msg_id,
		input  char_idx,
		output char,
		output last
	);

endinterface

`default_nettype wire

// ==== logic/msg_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_msg_defines.svh"

module msg_sequencer #(
	parameter int CLK_PER_BIT = `UART_CLK_PER_BIT,
	parameter int GAP_BITS = `UART_GAP_BITS
) (
	input  logic clock,
	input  logic arst_n,
	input  logic event_valid,
	input  uart_msg_pkg::msg_id_t event_id,
	msg_rom_if.seq rom,
	output logic tx_valid,
	output uart_msg_pkg::char_t tx_data,
	input  logic tx_ready,
	output logic busy
);

	localparam int unsigned GAP_CYCLES = GAP_BITS * CLK_PER_BIT;
	localparam int GAP_W = $clog2(GAP_CYCLES);

	uart_msg_pkg::seq_state_t state;
	uart_msg_pkg::msg_id_t msg_id_q;
	uart_msg_pkg::char_idx_t idx_q;
	logic last_q;
	logic [GAP_W-1:0] gap_cnt;

	assign rom.msg_id = msg_id_q;
	assign rom.char_idx = idx_q;
	assign busy = (state != uart_msg_pkg::SEQ_IDLE);

	//////////////////////////////
	// Message FSM
	//////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= uart_msg_pkg::SEQ_IDLE;
			msg_id_q <= uart_msg_pkg::MSG_RED;
			idx_q <= '0;
			tx_valid <= 1'b0;
			gap_cnt <= '0;
		end else begin
			case (state)
				uart_msg_pkg::SEQ_IDLE: begin
					if (event_valid) begin // Only place events are seen
						msg_id_q <= event_id;
						idx_q <= '0;
						state <= uart_msg_pkg::SEQ_LOAD;
					end
				end
				uart_msg_pkg::SEQ_LOAD: begin
					tx_valid <= 1'b1;
					state <= uart_msg_pkg::SEQ_SEND;
				end
				uart_msg_pkg::SEQ_SEND: begin
					if (tx_valid && tx_ready) begin
						tx_valid <= 1'b0;
						if (last_q) begin
							state <= uart_msg_pkg::SEQ_DRAIN;
						end else begin
							idx_q <= idx_q + 1'b1;
							state <= uart_msg_pkg::SEQ_LOAD;
						end
					end
				end
				uart_msg_pkg::SEQ_DRAIN: begin
					if (tx_ready) begin // Last stop bit has ended
						gap_cnt <= '0;
						state <= uart_msg_pkg::SEQ_GAP;
					end
				end
				uart_msg_pkg::SEQ_GAP: begin
					// DRAIN already used one cycle of the gap
					if (gap_cnt == GAP_W'(GAP_CYCLES - 2))
						state <= uart_msg_pkg::SEQ_IDLE;
					else
						gap_cnt <= gap_cnt + 1'b1;
				end
				default: state <= uart_msg_pkg::SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == uart_msg_pkg::SEQ_LOAD) begin
			tx_data <= rom.char;
			last_q <= rom.last;
		end
	end

	a_idx_range: assert property (@(posedge clock) disable iff (!arst_n)
		idx_q <= `MSG_MAX_LEN - 1);

	a_data_held: assert property (@(posedge clock) disable iff (!arst_n)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule

`default_nettype wire

// ==== logic/uart_msg_defines.svh ====
`ifndef UART_MSG_DEFINES_SVH
`define UART_MSG_DEFINES_SVH

//////////////////////////////
// Serial timing
//////////////////////////////

`define UART_CLK_PER_BIT 434 // 50 MHz at 115200 baud
`define UART_GAP_BITS 115200 // About one second of idle line

//////////////////////////////
// Frame and message sizes
//////////////////////////////

`define UART_DATA_BITS 8
`define MSG_MAX_LEN 12 // Pick and deposit strings

`endif

// ==== logic/uart_msg_pkg.sv ====
`default_nettype none

`include "uart_msg_defines.svh"

package uart_msg_pkg;

	typedef logic [`UART_DATA_BITS-1:0] char_t;
	typedef logic [2:0] msg_id_t;
	typedef logic [$clog2(`MSG_MAX_LEN)-1:0] char_idx_t;

	// Message numbers, also the bit order of the event inputs
	localparam msg_id_t MSG_RED   = 3'd0;
	localparam msg_id_t MSG_GREEN = 3'd1;
	localparam msg_id_t MSG_BLUE  = 3'd2;
	localparam msg_id_t MSG_PICK  = 3'd3;
	localparam msg_id_t MSG_DEPO  = 3'd4;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_LOAD,
		SEQ_SEND,
		SEQ_DRAIN,
		SEQ_GAP
	} seq_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage

`default_nettype wire

// ==== logic/uart_msg_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_msg_defines.svh"

module uart_msg_top #(
	parameter int CLK_PER_BIT = `UART_CLK_PER_BIT,
	parameter int GAP_BITS = `UART_GAP_BITS
) (
	input  logic clock,
	input  logic arst_n,
	input  logic red_event,
	input  logic green_event,
	input  logic blue_event,
	input  logic pick_event,
	input  logic depo_event,
	output logic tx,
	output logic busy
);

	logic event_valid;
	uart_msg_pkg::msg_id_t event_id;
	logic tx_valid;
	uart_msg_pkg::char_t tx_data;
	logic tx_ready;

	msg_rom_if i_rom_if ();

	event_capture i_event_capture (
		.clock       (clock),
		.arst_n      (arst_n),
		.red_event   (red_event),
		.green_event (green_event),
		.blue_event  (blue_event),
		.pick_event  (pick_event),
		.depo_event  (depo_event),
		.event_valid (event_valid),
		.event_id    (event_id)
	);

	msg_rom i_msg_rom (
		.rom (i_rom_if.rom)
	);

	msg_sequencer #(
		.CLK_PER_BIT (CLK_PER_BIT),
		.GAP_BITS    (GAP_BITS)
	) i_msg_sequencer (
		.clock       (clock),
		.arst_n      (arst_n),
		.event_valid (event_valid),
		.event_id    (event_id),
		.rom         (i_rom_if.seq),
		.tx_valid    (tx_valid),
		.tx_data     (tx_data),
		.tx_ready    (tx_ready),
		.busy        (busy)
	);

	uart_tx #(
		.CLK_PER_BIT (CLK_PER_BIT)
	) i_uart_tx (
		.clock    (clock),
		.arst_n   (arst_n),
		.tx_valid (tx_valid),
		.tx_data  (tx_data),
		.tx_ready (tx_ready),
		.tx       (tx)
	);

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_msg_defines.svh"

module uart_tx #(
	parameter int CLK_PER_BIT = `UART_CLK_PER_BIT
) (
	input  logic clock,
	input  logic arst_n,
	input  logic tx_valid,
	input  uart_msg_pkg::char_t tx_data,
	output logic tx_ready,
	output logic tx
);

	localparam int CNT_W = $clog2(CLK_PER_BIT);
	localparam int BIT_W = $clog2(`UART_DATA_BITS);

	uart_msg_pkg::tx_state_t state;
	logic [CNT_W-1:0] baud_cnt;
	logic [BIT_W-1:0] bit_cnt;
	uart_msg_pkg::char_t shreg;
	logic bit_end;

	assign bit_end = (baud_cnt == CNT_W'(CLK_PER_BIT - 1));
	assign tx_ready = (state == uart_msg_pkg::TX_IDLE);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= uart_msg_pkg::TX_IDLE;
			baud_cnt <= '0;
			bit_cnt <= '0;
			tx <= 1'b1;
		end else begin
			if (state == uart_msg_pkg::TX_IDLE || bit_end)
				baud_cnt <= '0;
			else
				baud_cnt <= baud_cnt + 1'b1;

			case (state)
				uart_msg_pkg::TX_IDLE: begin
					if (tx_valid) begin
						state <= uart_msg_pkg::TX_START;
						tx <= 1'b0; // Start bit
					end
				end
				uart_msg_pkg::TX_START: begin
					if (bit_end) begin
						state <= uart_msg_pkg::TX_DATA;
						bit_cnt <= '0;
						tx <= shreg[0]; // LSB first
					end
				end
				uart_msg_pkg::TX_DATA: begin
					if (bit_end) begin
						if (bit_cnt == BIT_W'(`UART_DATA_BITS - 1)) begin
							state <= uart_msg_pkg::TX_STOP;
							tx <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							tx <= shreg[0];
						end
					end
				end
				uart_msg_pkg::TX_STOP: begin
					if (bit_end)
						state <= uart_msg_pkg::TX_IDLE;
				end
				default: state <= uart_msg_pkg::TX_IDLE;
			endcase
		end
	end

	// Shifted at each bit end so bit 0 always holds the next data bit
	always_ff @(posedge clock) begin
		if (tx_ready && tx_valid)
			shreg <= tx_data;
		else if (bit_end && (state == uart_msg_pkg::TX_START || state == uart_msg_pkg::TX_DATA))
			shreg <= shreg >> 1;
	end

	a_idle_line_high: assert property (@(posedge clock) disable iff (!arst_n)
		state == uart_msg_pkg::TX_IDLE |-> tx);

endmodule

`default_nettype wire

// ==== tests/uart_frame_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_msg_defines.svh"

module uart_frame_monitor #(
	parameter int CLK_PER_BIT = `UART_CLK_PER_BIT
) (
	input  logic clock,
	input  logic arst_n,
	input  logic tx,
	output uart_msg_pkg::char_t rx_byte,
	output logic rx_valid,
	output logic frame_error
);

	initial begin
		rx_byte = '0;
		rx_valid = 1'b0;
		frame_error = 1'b0;
	end

	// Samples on falling clock edges, half a cycle clear of any tx change
	always begin : decode
		uart_msg_pkg::char_t data;
		@(negedge clock);
		if (arst_n && tx === 1'b0) begin
			repeat (CLK_PER_BIT / 2) @(negedge clock); // Middle of start bit
			a_start_low: assert (tx === 1'b0) else begin
				$display("[FAIL] %0t ns: tx = %b in start bit, expected 0", $time, tx);
				frame_error = 1'b1;
			end
			for (int i = 0; i < `UART_DATA_BITS; i++) begin
				repeat (CLK_PER_BIT) @(negedge clock);
				data[i] = tx; // LSB first
			end
			repeat (CLK_PER_BIT) @(negedge clock);
			a_stop_high: assert (tx === 1'b1) else begin
				$display("[FAIL] %0t ns: tx = %b in stop bit, expected 1", $time, tx);
				frame_error = 1'b1;
			end
			// Strobe spans the rising edge that ends the stop bit
			repeat (CLK_PER_BIT / 2 - 1) @(negedge clock);
			rx_byte = data;
			rx_valid = 1'b1;
			@(negedge clock);
			rx_valid = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== tests/uart_msg_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_msg_defines.svh"

module uart_msg_tb;

	localparam int CLK_PER_BIT = 8;
	localparam int GAP_BITS = 20;
	localparam int GAP_CYCLES = GAP_BITS * CLK_PER_BIT;
	localparam int FRAME_CYCLES = 10 * CLK_PER_BIT;
	localparam int NUM_COINCIDENT = 6;
	localparam int NUM_LOST = 6;
	localparam int NUM_MSGS = 5 + NUM_COINCIDENT + 2 * NUM_LOST + 3;
	localparam int MSG_CYCLES = `MSG_MAX_LEN * FRAME_CYCLES + GAP_CYCLES + 80;
	localparam int CYCLE_LIMIT = NUM_MSGS * MSG_CYCLES * 3 / 2;

	logic clock;
	logic arst_n;
	logic [4:0] events; // Deposit, pick, blue, green, red
	logic tx;
	logic busy;
	uart_msg_pkg::char_t rx_byte;
	logic rx_valid;
	logic frame_error;

	int unsigned lcg_state = 32'h4877_cb27;
	int unsigned cycle_cnt = 0;
	logic [8:0] exp_q[$]; // Last flag and character
	string msg_table[5];

	uart_msg_top #(
		.CLK_PER_BIT (CLK_PER_BIT),
		.GAP_BITS    (GAP_BITS)
	) i_dut (
		.clock       (clock),
		.arst_n      (arst_n),
		.red_event   (events[0]),
		.green_event (events[1]),
		.blue_event  (events[2]),
		.pick_event  (events[3]),
		.depo_event  (events[4]),
		.tx          (tx),
		.busy        (busy)
	);

	uart_frame_monitor #(
		.CLK_PER_BIT (CLK_PER_BIT)
	) i_monitor (
		.clock       (clock),
		.arst_n      (arst_n),
		.tx          (tx),
		.rx_byte     (rx_byte),
		.rx_valid    (rx_valid),
		.frame_error (frame_error)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic abort_run(string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
		abort_run($sformatf("[FAIL] %0t ns: %s = 0x%0h, expected 0x%0h",
			$time, name, got, want));
	endtask

	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int unsigned rand_range(int unsigned lo, int unsigned hi);
		return lo + (next_rand() >> 16) % (hi - lo + 1);
	endfunction

	// Higher bit wins, deposit down to red
	function automatic int unsigned top_event(logic [4:0] mask);
		int unsigned id;
		id = 0;
		for (int i = 0; i < 5; i++)
			if (mask[i])
				id = i;
		return id;
	endfunction

	task automatic set_events(logic [4:0] value);
		@(posedge clock);
		#1 events = value;
	endtask

	task automatic pulse(logic [4:0] mask, int unsigned hold);
		set_events(events | mask);
		repeat (hold - 1) @(posedge clock);
		set_events(events & ~mask);
	endtask

	task automatic expect_msg(int unsigned id);
		string text;
		text = msg_table[id];
		for (int i = 0; i < text.len(); i++)
			exp_q.push_back({(i == text.len() - 1), text[i]});
	endtask

	task automatic idle_check(int unsigned cycles);
		repeat (cycles) begin
			@(negedge clock);
			a_idle_busy: assert (busy === 1'b0) else report_mismatch("busy", busy, 1'b0);
			a_idle_tx: assert (tx === 1'b1) else report_mismatch("tx", tx, 1'b1);
		end
	endtask

	task automatic wait_busy_rise();
		while (busy !== 1'b1)
			@(negedge clock);
	endtask

	task automatic wait_message_end();
		while (busy !== 1'b0)
			@(negedge clock);
		a_all_chars: assert (exp_q.size() == 0) else
			abort_run($sformatf("Message ended with %0d expected characters missing",
				exp_q.size()));
	endtask

	// Runs from the edge that ends the last stop bit
	task automatic check_gap();
		repeat (GAP_CYCLES) begin
			@(negedge clock);
			a_gap_tx: assert (tx === 1'b1) else report_mismatch("tx", tx, 1'b1);
			a_gap_busy: assert (busy === 1'b1) else report_mismatch("busy", busy, 1'b1);
		end
		@(negedge clock);
		a_busy_fall: assert (busy === 1'b0) else report_mismatch("busy", busy, 1'b0);
	endtask

	task automatic served_message(logic [4:0] mask);
		expect_msg(top_event(mask));
		pulse(mask, rand_range(1, 4));
		wait_busy_rise();
		wait_message_end();
		idle_check(rand_range(5, 20));
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic lost_edges_test();
		int unsigned id;
		id = rand_range(0, 4);
		expect_msg(id);
		pulse(5'(1 << id), rand_range(1, 4));
		wait_busy_rise();
		repeat (rand_range(0, 600)) @(posedge clock);
		pulse(5'(rand_range(1, 31)), rand_range(1, 3)); // Mid message
		while (exp_q.size() != 0)
			@(negedge clock);
		repeat (rand_range(0, 100)) @(posedge clock);
		pulse(5'(rand_range(1, 31)), rand_range(1, 3)); // Inside the gap
		wait_message_end();
		idle_check(rand_range(5, 20));
		served_message(5'(1 << rand_range(0, 4)));
	endtask

	task automatic held_input_test();
		expect_msg(uart_msg_pkg::MSG_RED);
		set_events(events | 5'b00001);
		wait_busy_rise();
		wait_message_end();
		idle_check(40);
		served_message(5'b00100); // Red still high
		idle_check(40);
		set_events(events & ~5'b00001);
		idle_check(10);
		served_message(5'b00001);
	endtask

	initial begin
		logic [4:0] mask;
		arst_n = 1'b0;
		events = '0;
		msg_table[0] = "SI-SIN1-P-#";
		msg_table[1] = "SI-SIN1-N-#";
		msg_table[2] = "SI-SIN3-W-#";
		msg_table[3] = "S-P-DZN1-N-#";
		msg_table[4] = "S-D-DZN1-N-#";
		repeat (10) @(posedge clock);
		#1 arst_n = 1'b1;
		idle_check(20);
		for (int id = 0; id < 5; id++)
			served_message(5'(1 << id));
		repeat (NUM_COINCIDENT) begin
			mask = 5'(rand_range(1, 31));
			while ($countones(mask) < 2)
				mask = 5'(rand_range(1, 31));
			served_message(mask);
		end
		repeat (NUM_LOST)
			lost_edges_test();
		held_input_test();
		$display("Testbench passed");
		$finish;
	end

	//////////////////////////////
	// Checkers
	//////////////////////////////

	always @(posedge clock) begin : check_bytes
		logic [8:0] head;
		if (rx_valid) begin
			if (exp_q.size() == 0) begin
				abort_run($sformatf("Character 0x%02h arrived with no message expected",
					rx_byte));
			end else begin
				head = exp_q.pop_front();
				a_tx_byte: assert (rx_byte === head[7:0]) else
					report_mismatch("tx_byte", rx_byte, head[7:0]);
				if (head[8])
					check_gap();
			end
		end
	end

	a_idle_line: assert property (@(negedge clock) disable iff (!arst_n) !busy |-> tx)
		else abort_run("Serial line went low while the sender was idle");

	always @(posedge clock) begin
		cycle_cnt <= cycle_cnt + 1;
		if (frame_error)
			abort_run("Frame monitor found a bad start or stop bit");
		if (cycle_cnt >= CYCLE_LIMIT)
			abort_run("Timeout, the tests did not finish within the cycle limit");
	end

endmodule

`default_nettype wire

// ==== uart_msg.f ====
+incdir+logic
logic/uart_msg_pkg.sv
logic/msg_rom_if.sv
logic/event_capture.sv
logic/msg_rom.sv
logic/uart_tx.sv
logic/msg_sequencer.sv
logic/uart_msg_top.sv
tests/uart_frame_monitor.sv
tests/uart_msg_tb.sv
